// ==== design/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

	//////////////////// volume
	localparam int VOL_LEVELS = 16;
	localparam int LEVEL_W    = 5;                         // holds 1..16
	localparam int AMP_STEP   = 2048;

	localparam logic [LEVEL_W-1:0] LEVEL_MIN = LEVEL_W'(1);
	localparam logic [LEVEL_W-1:0] LEVEL_MAX = LEVEL_W'(VOL_LEVELS);

	//////////////////// buttons
	localparam int DEBOUNCE_CYCLES = 4;
	localparam int DB_CNT_W        = $clog2(DEBOUNCE_CYCLES);

	//////////////////// serial audio frame
	localparam int SAMPLE_BITS  = 16;
	localparam int SCK_DIV      = 4;                       // clk cycles per bit
	localparam int SCK_W        = $clog2(SCK_DIV);
	localparam int FRAME_CYCLES = 2 * SAMPLE_BITS * SCK_DIV;
	localparam int CYC_W        = $clog2(FRAME_CYCLES);

	typedef enum logic [1:0] {
		NOTE_MUTE,
		NOTE_DO,
		NOTE_MI,
		NOTE_SO
	} note_t;

	// half period of each note, in frames
	localparam int HP_W = 3;
	localparam logic [HP_W-1:0] HALF_DO = HP_W'(2);
	localparam logic [HP_W-1:0] HALF_MI = HP_W'(3);
	localparam logic [HP_W-1:0] HALF_SO = HP_W'(4);

	typedef struct packed {
		logic up_n;                                        // one-cycle low step
		logic down_n;
	} key_evt_t;

	typedef struct packed {
		logic [2:0]             tens_hi;                   // always zero for 1..16
		logic [LEVEL_W-1:0]     level;
		logic [SAMPLE_BITS-1:0] amplitude;
	} vol_t;

	typedef struct packed {
		logic signed [SAMPLE_BITS-1:0] left;
		logic signed [SAMPLE_BITS-1:0] right;
	} audio_sample_t;

	// level n gives n * AMP_STEP - 1
	function automatic logic [SAMPLE_BITS-1:0] amp_of_level(input logic [LEVEL_W-1:0] lvl);
		logic [31:0] prod;
		prod = 32'(lvl) * 32'(AMP_STEP) - 32'd1;
		return prod[SAMPLE_BITS-1:0];
	endfunction

	function automatic logic [HP_W-1:0] half_period(input note_t n);
		case (n)
			NOTE_DO: half_period = HALF_DO;
			NOTE_MI: half_period = HALF_MI;
			NOTE_SO: half_period = HALF_SO;
			default: half_period = HP_W'(1);              // mute never flips
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== design/key_pulse.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_pulse (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  key_up_n,
	input  wire                  key_down_n,
	output audio_pkg::key_evt_t  key_evt
);
	import audio_pkg::*;

	logic [1:0]          raw_n;                          // bit 0 up, bit 1 down
	logic [1:0]          sync1_n;
	logic [1:0]          sync2_n;
	logic [1:0]          stable_n;                       // debounced state
	logic [1:0]          accept;
	logic [1:0]          pulse_n;
	logic [DB_CNT_W-1:0] cnt [2];

	assign raw_n = {key_down_n, key_up_n};

	// new state seen for DEBOUNCE_CYCLES samples in a row
	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			accept[i] = (sync2_n[i] != stable_n[i]) &&
				(cnt[i] == DB_CNT_W'(DEBOUNCE_CYCLES - 1));
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync1_n  <= 2'b11;
			sync2_n  <= 2'b11;
			stable_n <= 2'b11;
			pulse_n  <= 2'b11;
			cnt[0]   <= '0;
			cnt[1]   <= '0;
		end
		else
		begin
			sync1_n <= raw_n;
			sync2_n <= sync1_n;
			for (int i = 0; i < 2; i++)
			begin
				if (sync2_n[i] == stable_n[i])
					cnt[i] <= '0;                           // bounce or idle
				else if (accept[i])
				begin
					cnt[i]      <= '0;
					stable_n[i] <= sync2_n[i];
				end
				else
					cnt[i] <= cnt[i] + DB_CNT_W'(1);
			end
			pulse_n <= ~(accept & ~sync2_n);              // press only, release is silent
		end
	end

	assign key_evt = '{up_n: pulse_n[0], down_n: pulse_n[1]};

endmodule

`default_nettype wire

// ==== design/volume_ctl.sv ====
`timescale 1ns/10ps
`default_nettype none

module volume_ctl (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire audio_pkg::key_evt_t key_evt,
	output audio_pkg::vol_t      vol,
	output logic [3:0]           vol_tens,
	output logic [3:0]           vol_unit
);
	import audio_pkg::*;

	logic [LEVEL_W-1:0]     level;
	logic [LEVEL_W-1:0]     level_nxt;
	logic [LEVEL_W-1:0]     unit_wide;
	logic [3:0]             tens_nxt;
	logic [3:0]             unit_nxt;
	logic [SAMPLE_BITS-1:0] amp;

	//////////////////// level step
	always_comb
	begin
		level_nxt = level;
		if (!key_evt.up_n)                               // up wins over down
		begin
			if (level != LEVEL_MAX)
				level_nxt = level + LEVEL_W'(1);
		end
		else if (!key_evt.down_n)
		begin
			if (level != LEVEL_MIN)
				level_nxt = level - LEVEL_W'(1);
		end
	end

	//////////////////// bcd of next level
	always_comb
	begin
		if (level_nxt >= LEVEL_W'(10))
		begin
			tens_nxt  = 4'd1;
			unit_wide = level_nxt - LEVEL_W'(10);
		end
		else
		begin
			tens_nxt  = 4'd0;
			unit_wide = level_nxt;
		end
		unit_nxt = unit_wide[3:0];                       // below ten here
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			level    <= LEVEL_MIN;
			amp      <= amp_of_level(LEVEL_MIN);
			vol_tens <= 4'd0;
			vol_unit <= 4'd1;
		end
		else
		begin
			level    <= level_nxt;
			amp      <= amp_of_level(level_nxt);
			vol_tens <= tens_nxt;
			vol_unit <= unit_nxt;
		end
	end

	assign vol = '{tens_hi: vol_tens[3:1], level: level, amplitude: amp};

endmodule

`default_nettype wire

// ==== design/tone_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tone_gen (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire audio_pkg::note_t       note,
	input  wire audio_pkg::vol_t        vol,
	input  wire                         frame_start,
	output audio_pkg::audio_sample_t    sample
);
	import audio_pkg::*;

	note_t                         note_q;           // note at last frame
	logic [HP_W-1:0]               hp_cnt;           // frames since last flip
	logic                          neg;              // current sign
	logic [HP_W-1:0]               cnt_nxt;
	logic                          neg_nxt;
	logic signed [SAMPLE_BITS-1:0] amp_s;
	logic signed [SAMPLE_BITS-1:0] smp_val;

	assign amp_s = signed'(vol.amplitude);

	always_comb
	begin
		cnt_nxt = hp_cnt + HP_W'(1);
		neg_nxt = neg;
		if (note == NOTE_MUTE)
		begin
			cnt_nxt = '0;
			neg_nxt = 1'b0;
		end
		else if (note != note_q)
			cnt_nxt = HP_W'(1);                          // restart, this frame is the first
		else if (hp_cnt == half_period(note) - HP_W'(1))
		begin
			cnt_nxt = '0;
			neg_nxt = ~neg;
		end

		if (note == NOTE_MUTE)
			smp_val = '0;
		else if (neg_nxt)
			smp_val = -amp_s;
		else
			smp_val = amp_s;
	end

	//////////////////// one update per frame
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			note_q <= NOTE_MUTE;
			hp_cnt <= '0;
			neg    <= 1'b0;
			sample <= '0;
		end
		else if (frame_start)
		begin
			note_q       <= note;
			hp_cnt       <= cnt_nxt;
			neg          <= neg_nxt;
			sample.left  <= smp_val;
			sample.right <= smp_val;                      // same tone on both channels
		end
	end

endmodule

`default_nettype wire

// ==== design/audio_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

module audio_serializer (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire audio_pkg::audio_sample_t sample,
	output logic                          frame_start,
	output logic                          sck,
	output logic                          lrck,
	output logic                          sdin
);
	import audio_pkg::*;

	localparam int WORD2 = 2 * SAMPLE_BITS;

	logic [CYC_W-1:0] cyc;                           // position in frame
	logic [WORD2-1:0] shreg;
	logic             bit_start;
	logic             frame_pos0;

	assign bit_start  = (cyc[SCK_W-1:0] == '0);
	assign frame_pos0 = (cyc == '0);

	//////////////////// frame timing
	// outputs lag cyc by one clock so all of them line up
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cyc         <= '0;
			frame_start <= 1'b0;
			sck         <= 1'b0;
			lrck        <= 1'b0;
			sdin        <= 1'b0;
		end
		else
		begin
			cyc         <= cyc + CYC_W'(1);                 // wraps every FRAME_CYCLES
			frame_start <= frame_pos0;
			sck         <= cyc[SCK_W-1];                    // low half, then high half
			lrck        <= cyc[CYC_W-1];                    // high for right word
			if (frame_pos0)
				sdin <= sample.left[SAMPLE_BITS-1];
			else if (bit_start)
				sdin <= shreg[WORD2-1];                      // changes with sck falling
		end
	end

	//////////////////// data shift
	always_ff @(posedge clk)
	begin
		if (frame_pos0)
			shreg <= {sample.left[SAMPLE_BITS-2:0], sample.right, 1'b0};
		else if (bit_start)
			shreg <= {shreg[WORD2-2:0], 1'b0};
	end

endmodule

`default_nettype wire

// ==== design/audio_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module audio_top (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   key_up_n,
	input  wire                   key_down_n,
	input  wire audio_pkg::note_t note,
	output logic [3:0]            vol_tens,
	output logic [3:0]            vol_unit,
	output logic                  sck,
	output logic                  lrck,
	output logic                  sdin
);
	import audio_pkg::*;

	key_evt_t      key_evt;
	vol_t          vol;
	audio_sample_t sample;
	logic          frame_start;                      // paces the tone generator

	key_pulse key_pulse_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.key_up_n   (key_up_n),
		.key_down_n (key_down_n),
		.key_evt    (key_evt)
	);

	volume_ctl volume_ctl_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.key_evt  (key_evt),
		.vol      (vol),
		.vol_tens (vol_tens),
		.vol_unit (vol_unit)
	);

	tone_gen tone_gen_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.note        (note),
		.vol         (vol),
		.frame_start (frame_start),
		.sample      (sample)
	);

	audio_serializer audio_serializer_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.sample      (sample),
		.frame_start (frame_start),
		.sck         (sck),
		.lrck        (lrck),
		.sdin        (sdin)
	);

endmodule

`default_nettype wire

// ==== bench/audio_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module audio_tb;
	import audio_pkg::*;

	localparam int SETTLE = 12;                          // release debounce plus pulse
	localparam int MARGIN = 1000;

	logic clk;
	logic rst_n;
	logic key_up_n;
	logic key_down_n;
	note_t note;
	logic [3:0] vol_tens;
	logic [3:0] vol_unit;
	logic sck;
	logic lrck;
	logic sdin;

	int model_level;
	int err_vol;
	int err_sample;
	int err_other;
	int cycles;
	int limit;
	int budget;

	audio_sample_t frames[$];
	bit            capturing;
	logic [31:0]   rx;
	int            bitcnt;

	audio_top audio_top_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.key_up_n   (key_up_n),
		.key_down_n (key_down_n),
		.note       (note),
		.vol_tens   (vol_tens),
		.vol_unit   (vol_unit),
		.sck        (sck),
		.lrck       (lrck),
		.sdin       (sdin)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout: run went past %0d cycles", limit);
			$display("Test failures found");
			$finish;
		end
	end

	//////////////////// frame monitor
	always @(posedge sck)
	begin
		check_bit("lrck", lrck, bitcnt >= SAMPLE_BITS);
		rx = {rx[30:0], sdin};
		bitcnt++;
		if (bitcnt == 2 * SAMPLE_BITS)
		begin
			bitcnt = 0;
			if (capturing)
				frames.push_back(audio_sample_t'(rx));     // left word came first
		end
	end

	//////////////////// compare tasks
	task automatic check_vol(input logic [3:0] exp_tens, input logic [3:0] exp_unit);
		if (vol_tens !== exp_tens)
		begin
			$display("ERR vol_tens got 0x%h exp 0x%h", vol_tens, exp_tens);
			err_vol++;
		end
		if (vol_unit !== exp_unit)
		begin
			$display("ERR vol_unit got 0x%h exp 0x%h", vol_unit, exp_unit);
			err_vol++;
		end
	endtask

	task automatic check_sample(input audio_sample_t got, input audio_sample_t exp);
		if (got.left !== exp.left)
		begin
			$display("ERR sample.left got 0x%h exp 0x%h", got.left, exp.left);
			err_sample++;
		end
		if (got.right !== exp.right)
		begin
			$display("ERR sample.right got 0x%h exp 0x%h", got.right, exp.right);
			err_sample++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h exp 0x%h", name, got, exp);
			err_other++;
		end
	endtask

	// frames per half period, straight from the note table
	function automatic int half_frames(input note_t n);
		case (n)
			NOTE_DO: return 2;
			NOTE_MI: return 3;
			NOTE_SO: return 4;
			default: return 0;
		endcase
	endfunction

	task automatic press_keys(input bit up, input bit down, input int hold, input int count);
		repeat (count)
		begin
			@(negedge clk);
			key_up_n   = !up;
			key_down_n = !down;
			repeat (hold) @(negedge clk);
			key_up_n   = 1'b1;
			key_down_n = 1'b1;
			repeat (SETTLE) @(negedge clk);
			if (hold >= DEBOUNCE_CYCLES)
			begin
				if (up)
				begin
					if (model_level < VOL_LEVELS)
						model_level++;                      // up wins
				end
				else if (model_level > 1)
					model_level--;
			end
		end
	endtask

	task automatic capture_frames(input int n);
		int            hp;
		int            first_chg;
		int            run;
		int            amp;
		bit            s;
		bit            ps;
		audio_sample_t got;
		audio_sample_t exp;
		@(negedge clk);
		frames.delete();
		capturing = 1'b1;
		while (frames.size() < n)
			@(posedge clk);
		capturing = 1'b0;
		hp        = half_frames(note);
		amp       = model_level * 2048 - 1;
		first_chg = -1;
		run       = 0;
		ps        = 1'b0;
		for (int i = 0; i < n; i++)
		begin
			got = frames[i];
			if (note == NOTE_MUTE)
				check_sample(got, '0);
			else
			begin
				s         = got.left[SAMPLE_BITS-1];
				exp.left  = 16'(s ? -amp : amp);
				exp.right = exp.left;
				check_sample(got, exp);
				if (i > 0 && s != ps)
				begin
					if (first_chg < 0)
						first_chg = i;
					else if (run != hp)
					begin
						$display("sign run of %0d frames, expected %0d", run, hp);
						err_other++;
					end
					run = 1;
				end
				else
					run++;
				ps = s;
			end
		end
		if (note != NOTE_MUTE)
		begin
			if (first_chg < 0)
			begin
				$display("tone never changed sign in %0d frames", n);
				err_other++;
			end
			else if (run > hp)
			begin
				$display("last sign run of %0d frames is too long", run);
				err_other++;
			end
		end
	endtask

	//////////////////// script
	// dry pass only sums the cycle budget
	task automatic run_script(input bit dry);
		int                fd;
		int                rc;
		int                a;
		int                b;
		string             word;
		reg [8*200-1:0]    line;
		fd = $fopen("bench/audio_input.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the stimulus file");
			$display("Test failures found");
			$finish;
		end
		while ($fscanf(fd, "%s", word) == 1)
		begin
			a = 0;
			b = 0;
			if (word == "#")
				rc = $fgets(line, fd);
			else if (word == "up" || word == "down" || word == "both")
			begin
				rc = $fscanf(fd, "%d %d", a, b);
				if (dry)
					budget += b * (a + SETTLE + 2);
				else
					press_keys(word != "down", word != "up", a, b);
			end
			else if (word == "note")
			begin
				rc = $fscanf(fd, "%d", a);
				if (!dry)
				begin
					@(negedge clk);
					note = note_t'(a[1:0]);
				end
			end
			else if (word == "idle")
			begin
				rc = $fscanf(fd, "%d", a);
				if (dry)
					budget += a;
				else
					repeat (a) @(negedge clk);
			end
			else if (word == "vol")
			begin
				rc = $fscanf(fd, "%d %d", a, b);
				if (!dry)
				begin
					check_vol(a[3:0], b[3:0]);
					if (model_level / 10 != a || model_level % 10 != b)
					begin
						$display("model level %0d disagrees with script digits", model_level);
						err_other++;
					end
				end
			end
			else if (word == "capture")
			begin
				rc = $fscanf(fd, "%d", a);
				if (dry)
					budget += (a + 2) * FRAME_CYCLES;
				else
					capture_frames(a);
			end
			else
			begin
				$display("unknown command %s in the stimulus file", word);
				err_other++;
			end
		end
		$fclose(fd);
	endtask

	initial
	begin
		rst_n       = 1'b0;
		key_up_n    = 1'b1;
		key_down_n  = 1'b1;
		note        = NOTE_MUTE;
		err_vol     = 0;
		err_sample  = 0;
		err_other   = 0;
		cycles      = 0;
		limit       = 1 << 30;
		budget      = 0;
		model_level = 1;
		capturing   = 1'b0;
		rx          = '0;
		bitcnt      = 0;
		run_script(1'b1);
		limit = budget + 5 + MARGIN;
		repeat (5) @(negedge clk);
		check_bit("sck", sck, 1'b0);
		check_bit("lrck", lrck, 1'b0);
		check_bit("sdin", sdin, 1'b0);
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("sck", sck, 1'b0);                     // first cycle of the first frame
		check_bit("lrck", lrck, 1'b0);
		check_bit("sdin", sdin, 1'b0);
		run_script(1'b0);
		$display("errors: vol=%0d sample=%0d other=%0d", err_vol, err_sample, err_other);
		if (err_vol + err_sample + err_other == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/audio_input.txt ====
# columns: command arg1 arg2; up/down/both = hold cycles and press count
# note 0..3 mute/do/mi/so, idle = cycles, vol = tens unit, capture = frames
vol 0 1
up 6 8
vol 0 9
up 6 1
vol 1 0
up 6 6
vol 1 6
up 6 2
vol 1 6
note 3
idle 400
capture 12
down 6 3
vol 1 3
note 1
idle 400
capture 10
both 6 1
vol 1 4
up 2 1
vol 1 4
down 6 13
vol 0 1
down 6 2
vol 0 1
note 2
idle 400
capture 10
note 0
idle 400
capture 6

// ==== sim.f ====
design/audio_pkg.sv
design/key_pulse.sv
design/volume_ctl.sv
design/tone_gen.sv
design/audio_serializer.sv
design/audio_top.sv
bench/audio_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the audio testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f sim.f --top-module audio_tb -o audio_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/audio_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
	exit 0
fi
exit 1
